/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP       := rat_tb
FILELIST  := build.f
SIM_FLAGS := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
common/rat_pkg.sv
common/rat_if.sv
rat_table/rat_entry.sv
rat_table/rat_table.sv
logic/rat_read_port.sv
logic/rat.sv
testbench/tb_clock.sv
testbench/rat_checker.sv
testbench/rat_scoreboard.sv
testbench/rat_tb.sv

/* common/rat_if.sv */
/* rename write port and table read lookup of the alias table
   rat drives the rename ports, the read ports look entries up in rat_table */
`timescale 1ns/10ps
`default_nettype none

// one rename slot carrying the newest writer of an architectural register
interface rename_write_if;
  import rat_pkg::*;

  arch_t addr;
  tag_t tag;
  fun_t fun;
  // already qualified by read_clk_en
  logic wen;

  modport src (
    output addr,
    output tag,
    output fun,
    output wen
  );

  modport dst (
    input addr,
    input tag,
    input fun,
    input wen
  );
endinterface

// one lookup into the entry array
interface table_read_if;
  import rat_pkg::*;

  arch_t addr;
  tag_t tag;
  fun_t fun;
  logic retired;

  modport req (output addr, input tag, input fun, input retired);
  modport rsp (input addr, output tag, output fun, output retired);
endinterface

`default_nettype wire

/* common/rat_pkg.sv */
/* widths, port counts, reset values and types shared by the register alias table
   imported by the interfaces and by every RTL module of the table */
`default_nettype none

package rat_pkg;

  // architectural entries and index width
  localparam int NUM_ARCH = 16;
  localparam int ARCH_W = 4;

  // the top bit of a read address selects the in-group bypass and the low bits name a slot
  localparam int READ_ADDR_W = 5;

  // port counts
  localparam int NUM_READ = 3;
  localparam int NUM_NEW = 3;
  localparam int NUM_RET = 3;

  // payload widths
  localparam int TAG_W = 9;
  localparam int FUN_W = 10;

  typedef logic [ARCH_W-1:0] arch_t;
  typedef logic [READ_ADDR_W-1:0] read_addr_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [FUN_W-1:0] fun_t;

  // values of an entry with no writer in flight
  localparam tag_t TAG_RESET = '1;
  localparam fun_t FUN_RESET = {1'b0, {(FUN_W-1){1'b1}}};

endpackage

`default_nettype wire

/* logic/rat.sv */
/* register alias table top level with plain array ports
   renames are gated by read_clk_en, retires and retire_all act every cycle */
`timescale 1ns/10ps
`default_nettype none

module rat (
  input  logic                clk,
  input  logic                rst,
  input  logic                read_clk_en,
  input  rat_pkg::read_addr_t read_addr [rat_pkg::NUM_READ],
  input  rat_pkg::arch_t      new_addr [rat_pkg::NUM_NEW],
  input  rat_pkg::tag_t       new_tag [rat_pkg::NUM_NEW],
  input  rat_pkg::fun_t       new_fun [rat_pkg::NUM_NEW],
  input  logic                new_wen [rat_pkg::NUM_NEW],
  input  rat_pkg::tag_t       ret_tag [rat_pkg::NUM_RET],
  input  logic                ret_wen [rat_pkg::NUM_RET],
  input  logic                retire_all,
  output rat_pkg::tag_t       read_tag [rat_pkg::NUM_READ],
  output rat_pkg::fun_t       read_fun [rat_pkg::NUM_READ],
  output logic                read_retired [rat_pkg::NUM_READ],
  output logic                read_is_dep [rat_pkg::NUM_READ]
);
  import rat_pkg::*;

  rename_write_if wr [NUM_NEW] ();
  table_read_if   rd [NUM_READ] ();

  // a stalled rename group writes nothing
  for (genvar p = 0; p < NUM_NEW; p++)
  begin : g_new
    assign wr[p].addr = new_addr[p];
    assign wr[p].tag = new_tag[p];
    assign wr[p].fun = new_fun[p];
    assign wr[p].wen = new_wen[p] & read_clk_en;
  end

  rat_table u_table (
    .clk        (clk),
    .rst        (rst),
    .write      (wr),
    .rd         (rd),
    .ret_tag    (ret_tag),
    .ret_wen    (ret_wen),
    .retire_all (retire_all)
  );

  for (genvar k = 0; k < NUM_READ; k++)
  begin : g_read
    rat_read_port u_read (
      .clk         (clk),
      .rst         (rst),
      .read_clk_en (read_clk_en),
      .addr        (read_addr[k]),
      .rd          (rd[k]),
      .slot        (wr),
      .tag         (read_tag[k]),
      .fun         (read_fun[k]),
      .retired     (read_retired[k]),
      .is_dep      (read_is_dep[k])
    );
  end

endmodule

`default_nettype wire

/* logic/rat_read_port.sv */
/* one read port of the alias table
   registers the address, then returns the table entry or the in-group rename slot */
`timescale 1ns/10ps
`default_nettype none

module rat_read_port (
  input  logic                clk,
  input  logic                rst,
  input  logic                read_clk_en,
  input  rat_pkg::read_addr_t addr,
  table_read_if.req           rd,
  rename_write_if.dst         slot [rat_pkg::NUM_NEW],
  output rat_pkg::tag_t       tag,
  output rat_pkg::fun_t       fun,
  output logic                retired,
  output logic                is_dep
);
  import rat_pkg::*;

  read_addr_t addr_q;
  tag_t slot_tag [NUM_NEW];
  fun_t slot_fun [NUM_NEW];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr_q <= '0;
    end
    else if (read_clk_en)
    begin
      addr_q <= addr;
    end
  end

  assign rd.addr = addr_q[ARCH_W-1:0];

  for (genvar s = 0; s < NUM_NEW; s++)
  begin : g_slot
    assign slot_tag[s] = slot[s].tag;
    assign slot_fun[s] = slot[s].fun;
  end

  // in bypass the low two bits name the slot and an unused slot reads as reset values
  always_comb
  begin
    if (addr_q[READ_ADDR_W-1])
    begin
      tag = TAG_RESET;
      fun = FUN_RESET;
      for (int i = 0; i < NUM_NEW; i++)
      begin
        if (addr_q[1:0] == 2'(i))
        begin
          tag = slot_tag[i];
          fun = slot_fun[i];
        end
      end
      retired = 1'b0;
      is_dep = 1'b1;
    end
    else
    begin
      tag = rd.tag;
      fun = rd.fun;
      retired = rd.retired;
      is_dep = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rat_table/rat_entry.sv */
/* one architectural register of the alias table
   captures the newest rename to INDEX and tracks whether that writer has retired */
`timescale 1ns/10ps
`default_nettype none

module rat_entry #(
  parameter int INDEX = 0
) (
  input  logic               clk,
  input  logic               rst,
  rename_write_if.dst        write [rat_pkg::NUM_NEW],
  input  rat_pkg::tag_t      ret_tag [rat_pkg::NUM_RET],
  input  logic               ret_wen [rat_pkg::NUM_RET],
  input  logic               retire_all,
  output rat_pkg::tag_t      tag,
  output rat_pkg::fun_t      fun,
  output logic               retired
);
  import rat_pkg::*;

  localparam arch_t MY_ADDR = arch_t'(INDEX);

  logic [NUM_NEW-1:0] hit_new;
  tag_t new_tag [NUM_NEW];
  fun_t new_fun [NUM_NEW];
  logic [NUM_RET-1:0] hit_ret;
  tag_t win_tag;
  fun_t win_fun;

  for (genvar p = 0; p < NUM_NEW; p++)
  begin : g_new
    assign hit_new[p] = write[p].wen && (write[p].addr == MY_ADDR);
    assign new_tag[p] = write[p].tag;
    assign new_fun[p] = write[p].fun;
  end

  // a retire port matches when its rob tag equals the stored writer
  for (genvar r = 0; r < NUM_RET; r++)
  begin : g_ret
    assign hit_ret[r] = ret_wen[r] && (ret_tag[r] == tag);
  end

  // later slots are younger in program order, so the highest port wins
  always_comb
  begin
    win_tag = tag;
    win_fun = fun;
    for (int i = 0; i < NUM_NEW; i++)
    begin
      if (hit_new[i])
      begin
        win_tag = new_tag[i];
        win_fun = new_fun[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tag <= TAG_RESET;
      fun <= FUN_RESET;
      retired <= 1'b1;
    end
    else if (|hit_new)
    begin
      // a new writer in flight beats any retire in this cycle
      tag <= win_tag;
      fun <= win_fun;
      retired <= 1'b0;
    end
    else if (|hit_ret || retire_all)
    begin
      retired <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rat_table/rat_table.sv */
/* array of alias entries with one combinational lookup per read port
   rename and retire traffic is broadcast to every entry */
`timescale 1ns/10ps
`default_nettype none

module rat_table (
  input  logic          clk,
  input  logic          rst,
  rename_write_if.dst   write [rat_pkg::NUM_NEW],
  table_read_if.rsp     rd [rat_pkg::NUM_READ],
  input  rat_pkg::tag_t ret_tag [rat_pkg::NUM_RET],
  input  logic          ret_wen [rat_pkg::NUM_RET],
  input  logic          retire_all
);
  import rat_pkg::*;

  tag_t ent_tag [NUM_ARCH];
  fun_t ent_fun [NUM_ARCH];
  logic ent_retired [NUM_ARCH];

  // each entry decodes the rename addresses itself
  for (genvar e = 0; e < NUM_ARCH; e++)
  begin : g_entry
    rat_entry #(
      .INDEX(e)
    ) u_entry (
      .clk        (clk),
      .rst        (rst),
      .write      (write),
      .ret_tag    (ret_tag),
      .ret_wen    (ret_wen),
      .retire_all (retire_all),
      .tag        (ent_tag[e]),
      .fun        (ent_fun[e]),
      .retired    (ent_retired[e])
    );
  end

  // lookups follow the registered address and show the state after the last edge
  for (genvar k = 0; k < NUM_READ; k++)
  begin : g_read
    assign rd[k].tag = ent_tag[rd[k].addr];
    assign rd[k].fun = ent_fun[rd[k].addr];
    assign rd[k].retired = ent_retired[rd[k].addr];
  end

endmodule

`default_nettype wire

/* testbench/rat_checker.sv */
/* concurrent assertions on the read outputs of rat
   attached to every rat instance by the bind at the end of this file */
`timescale 1ns/10ps
`default_nettype none

module rat_checker (
  input logic                clk,
  input logic                rst,
  input logic                read_clk_en,
  input logic                new_wen [rat_pkg::NUM_NEW],
  input logic                retire_all,
  input rat_pkg::tag_t       read_tag [rat_pkg::NUM_READ],
  input rat_pkg::fun_t       read_fun [rat_pkg::NUM_READ],
  input logic                read_retired [rat_pkg::NUM_READ],
  input logic                read_is_dep [rat_pkg::NUM_READ]
);
  import rat_pkg::*;

  logic reset_seen = 1'b0;
  logic any_rename;
  int fail_count = 0;

  always @(posedge clk)
  begin
    if (rst)
    begin
      reset_seen <= 1'b1;
    end
  end

  always_comb
  begin
    any_rename = 1'b0;
    for (int p = 0; p < NUM_NEW; p++)
    begin
      any_rename = any_rename | new_wen[p];
    end
    any_rename = any_rename & read_clk_en;
  end

  for (genvar k = 0; k < NUM_READ; k++)
  begin : g_port
    a_dep_not_retired : assert property (@(posedge clk) disable iff (rst)
      read_is_dep[k] |-> !read_retired[k])
    else
    begin
      fail_count++;
      $error("read port %0d shows a bypass result marked retired", k);
    end

    a_outputs_known : assert property (@(posedge clk) disable iff (rst || !reset_seen)
      !$isunknown(read_tag[k]) && !$isunknown(read_fun[k]) &&
      !$isunknown(read_retired[k]) && !$isunknown(read_is_dep[k]))
    else
    begin
      fail_count++;
      $error("read port %0d has an unknown output after reset", k);
    end

    // every entry is retired once a retire-all edge saw no rename
    a_retire_all : assert property (@(posedge clk) disable iff (rst)
      (retire_all && !any_rename) |=> (read_is_dep[k] || read_retired[k]))
    else
    begin
      fail_count++;
      $error("read port %0d shows a live entry right after retire-all", k);
    end
  end

endmodule

bind rat rat_checker u_checker (
  .clk          (clk),
  .rst          (rst),
  .read_clk_en  (read_clk_en),
  .new_wen      (new_wen),
  .retire_all   (retire_all),
  .read_tag     (read_tag),
  .read_fun     (read_fun),
  .read_retired (read_retired),
  .read_is_dep  (read_is_dep)
);

`default_nettype wire

/* testbench/rat_scoreboard.sv */
/* reference model of the alias table and comparison against the DUT read outputs
   compares on every rising edge, prints a line per test and the closing counts */
`timescale 1ns/10ps
`default_nettype none

module rat_scoreboard #(
  parameter int NUM_TESTS = 5
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                read_clk_en,
  input  rat_pkg::read_addr_t read_addr [rat_pkg::NUM_READ],
  input  rat_pkg::arch_t      new_addr [rat_pkg::NUM_NEW],
  input  rat_pkg::tag_t       new_tag [rat_pkg::NUM_NEW],
  input  rat_pkg::fun_t       new_fun [rat_pkg::NUM_NEW],
  input  logic                new_wen [rat_pkg::NUM_NEW],
  input  rat_pkg::tag_t       ret_tag [rat_pkg::NUM_RET],
  input  logic                ret_wen [rat_pkg::NUM_RET],
  input  logic                retire_all,
  input  rat_pkg::tag_t       read_tag [rat_pkg::NUM_READ],
  input  rat_pkg::fun_t       read_fun [rat_pkg::NUM_READ],
  input  logic                read_retired [rat_pkg::NUM_READ],
  input  logic                read_is_dep [rat_pkg::NUM_READ],
  input  int                  test_id,
  output int                  error_count,
  output int                  check_count
);
  import rat_pkg::*;

  tag_t m_tag [NUM_ARCH];
  fun_t m_fun [NUM_ARCH];
  logic m_retired [NUM_ARCH];
  read_addr_t m_addr [NUM_READ];
  logic model_valid = 1'b0;
  int cur_test = -1;
  int test_checks = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  initial
  begin
    error_count = 0;
    check_count = 0;
  end

  function automatic string test_name(int id);
    case (id)
      0: return "reset_state";
      1: return "rename";
      2: return "retire";
      3: return "retire_all";
      4: return "bypass";
      default: return "idle";
    endcase
  endfunction

  task automatic check_field(string field, int port, logic [31:0] expected,
                             logic [31:0] actual);
    check_count++;
    test_checks++;
    if (actual !== expected)
    begin
      error_count++;
      test_errors++;
      $display("[FAIL] %0s port %0d %0s: expected 0x%0h, actual 0x%0h",
               test_name(cur_test), port, field, expected, actual);
    end
  endtask

  // outputs held since the falling edge are checked against the state before this edge
  task automatic compare_outputs();
    int slot;
    int e;
    tag_t exp_tag;
    fun_t exp_fun;
    logic exp_retired;
    logic exp_dep;
    for (int k = 0; k < NUM_READ; k++)
    begin
      if (m_addr[k][READ_ADDR_W-1])
      begin
        slot = int'(m_addr[k][1:0]);
        exp_tag = (slot < NUM_NEW) ? new_tag[slot] : TAG_RESET;
        exp_fun = (slot < NUM_NEW) ? new_fun[slot] : FUN_RESET;
        exp_retired = 1'b0;
        exp_dep = 1'b1;
      end
      else
      begin
        e = int'(m_addr[k][ARCH_W-1:0]);
        exp_tag = m_tag[e];
        exp_fun = m_fun[e];
        exp_retired = m_retired[e];
        exp_dep = 1'b0;
      end
      check_field("tag", k, 32'(exp_tag), 32'(read_tag[k]));
      check_field("fun", k, 32'(exp_fun), 32'(read_fun[k]));
      check_field("retired", k, 32'(exp_retired), 32'(read_retired[k]));
      check_field("is_dep", k, 32'(exp_dep), 32'(read_is_dep[k]));
    end
  endtask

  task automatic update_model();
    logic hit;
    tag_t win_tag;
    fun_t win_fun;
    for (int e = 0; e < NUM_ARCH; e++)
    begin
      hit = 1'b0;
      win_tag = m_tag[e];
      win_fun = m_fun[e];
      // later ports overwrite earlier ones
      for (int p = 0; p < NUM_NEW; p++)
      begin
        if (read_clk_en && new_wen[p] && new_addr[p] == arch_t'(e))
        begin
          hit = 1'b1;
          win_tag = new_tag[p];
          win_fun = new_fun[p];
        end
      end
      if (hit)
      begin
        m_tag[e] = win_tag;
        m_fun[e] = win_fun;
        m_retired[e] = 1'b0;
      end
      else
      begin
        for (int r = 0; r < NUM_RET; r++)
        begin
          if (ret_wen[r] && ret_tag[r] == m_tag[e])
          begin
            m_retired[e] = 1'b1;
          end
        end
        if (retire_all)
        begin
          m_retired[e] = 1'b1;
        end
      end
    end
    if (read_clk_en)
    begin
      m_addr = read_addr;
    end
  endtask

  always @(posedge clk)
  begin
    // these outputs come from the previous cycle's stimulus, so they count for that test
    if (model_valid && !rst && cur_test != NUM_TESTS)
    begin
      compare_outputs();
    end
    if (test_id != cur_test)
    begin
      if (cur_test >= 0 && cur_test < NUM_TESTS)
      begin
        tests_run++;
        if (test_errors != 0)
        begin
          tests_failed++;
        end
        $display("test %0s: %0d checks, %0d errors", test_name(cur_test),
                 test_checks, test_errors);
      end
      cur_test = test_id;
      test_checks = 0;
      test_errors = 0;
      if (cur_test == NUM_TESTS)
      begin
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
      end
    end
    if (rst)
    begin
      for (int e = 0; e < NUM_ARCH; e++)
      begin
        m_tag[e] = TAG_RESET;
        m_fun[e] = FUN_RESET;
        m_retired[e] = 1'b1;
      end
      for (int k = 0; k < NUM_READ; k++)
      begin
        m_addr[k] = '0;
      end
      model_valid = 1'b1;
    end
    else if (model_valid)
    begin
      update_model();
    end
  end

endmodule

`default_nettype wire

/* testbench/rat_tb.sv */
/* testbench top for the register alias table
   drives random rename, retire and read traffic per test on the falling edge */
`timescale 1ns/10ps
`default_nettype none

module rat_tb;
  import rat_pkg::*;

  localparam int SEED = 18975;
  localparam int NUM_TESTS = 5;
  localparam int CLK_PERIOD_NS = 10;
  localparam int RESET_CYCLES = 3;
  localparam int READOUT_CYCLES = 7;
  localparam int RENAME_CYCLES = 200;
  localparam int RETIRE_CYCLES = 200;
  localparam int RETIRE_ALL_CYCLES = 150;
  localparam int BYPASS_CYCLES = 150;
  localparam int TOTAL_CYCLES = RESET_CYCLES + READOUT_CYCLES + RENAME_CYCLES +
                                RETIRE_CYCLES + RETIRE_ALL_CYCLES + BYPASS_CYCLES + 3;
  localparam int WATCHDOG_NS = (TOTAL_CYCLES + 50) * CLK_PERIOD_NS;

  logic clk;
  logic rst;
  logic read_clk_en;
  logic retire_all;
  read_addr_t read_addr [NUM_READ];
  arch_t new_addr [NUM_NEW];
  tag_t new_tag [NUM_NEW];
  fun_t new_fun [NUM_NEW];
  logic new_wen [NUM_NEW];
  tag_t ret_tag [NUM_RET];
  logic ret_wen [NUM_RET];
  tag_t read_tag [NUM_READ];
  fun_t read_fun [NUM_READ];
  logic read_retired [NUM_READ];
  logic read_is_dep [NUM_READ];
  int test_id;
  int sb_errors;
  int sb_checks;
  // recently written tags let retires hit stored entries
  tag_t tag_pool [$];

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  rat u_dut (
    .clk          (clk),
    .rst          (rst),
    .read_clk_en  (read_clk_en),
    .read_addr    (read_addr),
    .new_addr     (new_addr),
    .new_tag      (new_tag),
    .new_fun      (new_fun),
    .new_wen      (new_wen),
    .ret_tag      (ret_tag),
    .ret_wen      (ret_wen),
    .retire_all   (retire_all),
    .read_tag     (read_tag),
    .read_fun     (read_fun),
    .read_retired (read_retired),
    .read_is_dep  (read_is_dep)
  );

  rat_scoreboard #(
    .NUM_TESTS (NUM_TESTS)
  ) u_sb (
    .clk          (clk),
    .rst          (rst),
    .read_clk_en  (read_clk_en),
    .read_addr    (read_addr),
    .new_addr     (new_addr),
    .new_tag      (new_tag),
    .new_fun      (new_fun),
    .new_wen      (new_wen),
    .ret_tag      (ret_tag),
    .ret_wen      (ret_wen),
    .retire_all   (retire_all),
    .read_tag     (read_tag),
    .read_fun     (read_fun),
    .read_retired (read_retired),
    .read_is_dep  (read_is_dep),
    .test_id      (test_id),
    .error_count  (sb_errors),
    .check_count  (sb_checks)
  );

  task automatic quiet_traffic();
    retire_all = 1'b0;
    for (int p = 0; p < NUM_NEW; p++)
    begin
      new_wen[p] = 1'b0;
    end
    for (int r = 0; r < NUM_RET; r++)
    begin
      ret_wen[r] = 1'b0;
    end
  endtask

  task automatic clear_inputs();
    read_clk_en = 1'b0;
    quiet_traffic();
    for (int p = 0; p < NUM_NEW; p++)
    begin
      new_addr[p] = '0;
      new_tag[p] = '0;
      new_fun[p] = '0;
    end
    for (int r = 0; r < NUM_RET; r++)
    begin
      ret_tag[r] = '0;
    end
    for (int k = 0; k < NUM_READ; k++)
    begin
      read_addr[k] = '0;
    end
  endtask

  task automatic drive_renames(int addr_range, int wen_percent);
    for (int p = 0; p < NUM_NEW; p++)
    begin
      new_wen[p] = ($urandom % 100) < wen_percent;
      new_addr[p] = arch_t'($urandom % addr_range);
      new_tag[p] = tag_t'($urandom);
      new_fun[p] = fun_t'($urandom);
      if (new_wen[p])
      begin
        tag_pool.push_back(new_tag[p]);
        if (tag_pool.size() > 32)
        begin
          void'(tag_pool.pop_front());
        end
      end
    end
  endtask

  task automatic drive_retires(int pool_percent);
    for (int r = 0; r < NUM_RET; r++)
    begin
      ret_wen[r] = ($urandom % 2) == 0;
      if (tag_pool.size() > 0 && ($urandom % 100) < pool_percent)
      begin
        ret_tag[r] = tag_pool[$urandom % tag_pool.size()];
      end
      else
      begin
        ret_tag[r] = tag_t'($urandom);
      end
    end
  endtask

  task automatic drive_table_reads();
    for (int k = 0; k < NUM_READ; k++)
    begin
      read_addr[k] = read_addr_t'($urandom % NUM_ARCH);
    end
  endtask

  // slot 3 does not exist and is picked on purpose
  task automatic drive_bypass_reads();
    for (int k = 0; k < NUM_READ; k++)
    begin
      if (($urandom % 4) == 0)
      begin
        read_addr[k] = read_addr_t'($urandom % NUM_ARCH);
      end
      else
      begin
        read_addr[k] = {1'b1, 2'b00, 2'($urandom % 4)};
      end
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    clear_inputs();
    test_id = -1;
    wait (rst == 1'b0);

    // read every entry once after reset with three reads per cycle
    for (int i = 0; i < READOUT_CYCLES - 1; i++)
    begin
      @(negedge clk);
      test_id = 0;
      read_clk_en = 1'b1;
      for (int k = 0; k < NUM_READ; k++)
      begin
        read_addr[k] = read_addr_t'((NUM_READ * i + k) % NUM_ARCH);
      end
    end
    @(negedge clk);
    read_clk_en = 1'b0;

    // first half aims at four entries to force port collisions
    for (int i = 0; i < RENAME_CYCLES; i++)
    begin
      @(negedge clk);
      test_id = 1;
      read_clk_en = ($urandom % 4) != 0;
      drive_renames((i < RENAME_CYCLES / 2) ? 4 : NUM_ARCH, 75);
      drive_table_reads();
    end

    for (int i = 0; i < RETIRE_CYCLES; i++)
    begin
      @(negedge clk);
      test_id = 2;
      read_clk_en = ($urandom % 4) != 0;
      drive_renames(NUM_ARCH, 30);
      drive_retires(75);
      drive_table_reads();
    end

    for (int i = 0; i < RETIRE_ALL_CYCLES; i++)
    begin
      @(negedge clk);
      test_id = 3;
      read_clk_en = ($urandom % 4) != 0;
      drive_renames(NUM_ARCH, 20);
      drive_retires(50);
      retire_all = ($urandom % 6) == 0;
      drive_table_reads();
    end

    for (int i = 0; i < BYPASS_CYCLES; i++)
    begin
      @(negedge clk);
      test_id = 4;
      quiet_traffic();
      read_clk_en = ($urandom % 4) != 0;
      drive_renames(NUM_ARCH, 50);
      drive_bypass_reads();
    end

    @(negedge clk);
    quiet_traffic();
    test_id = NUM_TESTS;
    @(posedge clk);
    @(negedge clk);
    if (u_dut.u_checker.fail_count != 0)
    begin
      $display("assertion failures: %0d", u_dut.u_checker.fail_count);
    end
    if (sb_checks == 0)
    begin
      $display("no DUT outputs were compared");
    end
    if (sb_errors == 0 && sb_checks > 0 && u_dut.u_checker.fail_count == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
/* clock and reset for the alias table testbench
   10 ns clock, reset held for two rising edges and released on a falling edge */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);
  localparam int HALF_PERIOD_NS = 5;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire
